/* bench/dmem_tb.sv */
`default_nettype none

module dmem_tb
	import dmem_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ADDR_BITS = 8;
	localparam int DEPTH     = 2**ADDR_BITS;
	localparam int TIMEOUT   = 2000;		// Cycles allowed per wait

	logic    clock;
	logic    reset;
	logic    stall;
	logic    req      [2][1:2];			// Index 0 is store and 1 is load
	logic    valid    [2][1:2];
	length_t len_f    [2][1:2];
	stride_t stride_f [2][1:2];
	addr_t   base_f   [2][1:2];
	data_t   st_data  [1:2];
	logic    st_grant_1, st_grant_2, ld_grant_1, ld_grant_2;
	logic    st_ready_1, st_ready_2, ld_ready_1, ld_ready_2;
	data_t   ld_data_1, ld_data_2;

	logic [31:0] lfsr = 32'd74854;
	bit          stall_mode = 1'b0;
	data_t       model [DEPTH];			// Reference memory
	data_t       exp_1 [$];				// Expected load words per port
	data_t       exp_2 [$];
	int          grant_order [$];
	int          pulses [1:2] = '{0, 0};
	int          steps [2][1:2] = '{'{0, 0}, '{0, 0}};
	int          k_dir [2] = '{0, 0};
	int          last_pending [2] = '{0, 0};
	logic        prev_grant [2][1:2] = '{'{0, 0}, '{0, 0}};
	logic        load_due [1:2] = '{0, 0};	// Load step seen in the previous cycle
	int          errors = 0;
	int          tests = 0;
	int          failed = 0;
	int          errors_at_start = 0;

	dmem_body #(.ADDR_BITS(ADDR_BITS)) uut (
		.clock (clock), .reset (reset), .stall (stall),
		.st_req_1 (req[0][1]), .st_req_2 (req[0][2]),
		.ld_req_1 (req[1][1]), .ld_req_2 (req[1][2]),
		.st_length_1 (len_f[0][1]), .st_length_2 (len_f[0][2]),
		.ld_length_1 (len_f[1][1]), .ld_length_2 (len_f[1][2]),
		.st_stride_1 (stride_f[0][1]), .st_stride_2 (stride_f[0][2]),
		.ld_stride_1 (stride_f[1][1]), .ld_stride_2 (stride_f[1][2]),
		.st_base_1 (base_f[0][1]), .st_base_2 (base_f[0][2]),
		.ld_base_1 (base_f[1][1]), .ld_base_2 (base_f[1][2]),
		.st_valid_1 (valid[0][1]), .st_valid_2 (valid[0][2]),
		.ld_valid_1 (valid[1][1]), .ld_valid_2 (valid[1][2]),
		.st_data_1 (st_data[1]), .st_data_2 (st_data[2]),
		.st_grant_1 (st_grant_1), .st_grant_2 (st_grant_2),
		.ld_grant_1 (ld_grant_1), .ld_grant_2 (ld_grant_2),
		.st_ready_1 (st_ready_1), .st_ready_2 (st_ready_2),
		.ld_data_1 (ld_data_1), .ld_data_2 (ld_data_2),
		.ld_ready_1 (ld_ready_1), .ld_ready_2 (ld_ready_2)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////
	// Helpers

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic        b;
		value = '0;
		for (int i = 0; i < n; i++) begin
			b     = lfsr[0];
			lfsr  = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
			value = (value << 1) | 32'(b);
		end
		return value;
	endfunction

	function automatic logic grant_of(input int dir, input int p);
		if (dir == 0) begin
			return (p == 1) ? st_grant_1 : st_grant_2;
		end
		return (p == 1) ? ld_grant_1 : ld_grant_2;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("MISMATCH %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
		errors++;
	endtask

	task automatic report_error(input string what);
		$display("error: %s at %0t", what, $time);
		errors++;
	endtask

	task automatic timeout_abort(input string what);
		$display("error: timeout waiting for %s", what);
		$display("tests failed");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == errors_at_start) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: FAILED with %0d errors", tests, name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clock);
		#2;
	endtask

	task automatic drive_word(input int dir, input int p, input bit gaps);
		valid[dir][p] = gaps ? (rand_bits(2) != 0) : 1'b1;
		if (dir == 0) begin
			st_data[p] = rand_bits(32);
		end
	endtask

	// Requests one stream and keeps it up until its grant falls
	task automatic run_stream(input int dir, input int p, input int base, input int stride,
			input int len, input bit gaps);
		int n;
		base_f[dir][p]   = addr_t'(base);
		stride_f[dir][p] = stride_t'(stride);
		len_f[dir][p]    = length_t'(len);
		req[dir][p]      = 1'b1;
		drive_word(dir, p, gaps);
		n = 0;
		while (!grant_of(dir, p)) begin
			@(posedge clock);
			#2;
			drive_word(dir, p, gaps);
			n++;
			if (n > TIMEOUT) timeout_abort("a stream grant");
		end
		n = 0;
		while (grant_of(dir, p)) begin
			@(posedge clock);
			#2;
			drive_word(dir, p, gaps);
			n++;
			if (n > TIMEOUT) timeout_abort("the end of a stream");
		end
		req[dir][p]   = 1'b0;
		valid[dir][p] = 1'b0;
	endtask

	////////////////////
	// Monitor and checks

	task automatic track(input int dir, input int p, input logic grant, input data_t wdata);
		int a;
		if (grant && !prev_grant[dir][p]) begin
			k_dir[dir] = 0;				// New stream owns this engine
			if (dir == 0) begin
				grant_order.push_back(p);
			end
		end
		if (grant && valid[dir][p] && !stall) begin
			if (k_dir[dir] >= int'(len_f[dir][p])) report_error("step beyond stream length");
			a = (int'(base_f[dir][p]) + k_dir[dir] * int'(stride_f[dir][p])) % DEPTH;
			if (dir == 1) begin
				if (p == 1) exp_1.push_back(model[a]);
				else exp_2.push_back(model[a]);
				load_due[p] = 1'b1;
			end else begin
				model[a] = wdata;
			end
			steps[dir][p]++;
			k_dir[dir]++;
			if (k_dir[dir] == int'(len_f[dir][p])) last_pending[dir] = 1;
		end
		prev_grant[dir][p] = grant;
	endtask

	task automatic check_return(input int p, input logic ready, input data_t data);
		data_t exp;
		// Each pulse comes exactly one cycle after its load step
		assert (ready == load_due[p])
			else report_mismatch($sformatf("ld_ready_%0d", p), 32'(ready),
				32'(load_due[p]));
		load_due[p] = 1'b0;
		assert (ready || data == '0) else report_mismatch($sformatf("ld_data_%0d", p), data, 0);
		if (ready) begin
			pulses[p]++;
			if ((p == 1 && exp_1.size() == 0) || (p == 2 && exp_2.size() == 0)) begin
				report_error($sformatf("load word on port %0d without a step", p));
			end else begin
				exp = (p == 1) ? exp_1.pop_front() : exp_2.pop_front();
				assert (data === exp) else report_mismatch($sformatf("ld_data_%0d", p), data, exp);
			end
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clock) begin
		if (!reset) begin
			assert (!(st_grant_1 && st_grant_2)) else report_error("both store grants high");
			assert (!(ld_grant_1 && ld_grant_2)) else report_error("both load grants high");
			assert (st_ready_1 == (st_grant_1 && !stall))
				else report_mismatch("st_ready_1", 32'(st_ready_1), 32'(st_grant_1 && !stall));
			assert (st_ready_2 == (st_grant_2 && !stall))
				else report_mismatch("st_ready_2", 32'(st_ready_2), 32'(st_grant_2 && !stall));
			for (int d = 0; d < 2; d++) begin
				if (last_pending[d] != 0) begin
					assert (!grant_of(d, 1) && !grant_of(d, 2))
						else report_error("grant still high after the last step");
					last_pending[d] = 0;
				end
			end
			check_return(1, ld_ready_1, ld_data_1);
			check_return(2, ld_ready_2, ld_data_2);
			track(1, 1, ld_grant_1, '0);		// Loads before stores so a read sees old data
			track(1, 2, ld_grant_2, '0);
			track(0, 1, st_grant_1, st_data[1]);
			track(0, 2, st_grant_2, st_data[2]);
		end
	end

	always @(posedge clock) begin
		#2;
		stall = stall_mode ? (rand_bits(2) == 0) : 1'b0;
	end

	task automatic check_count(input string name, input int got, input int exp);
		assert (got == exp) else report_mismatch(name, got, exp);
	endtask

	task automatic tie_break(input int first, input int base_1, input int base_2);
		grant_order.delete();
		fork
			run_stream(0, 1, base_1, 1, 6, 1'b0);
			run_stream(0, 2, base_2, 2, 6, 1'b0);
		join
		check_count("grant order length", grant_order.size(), 2);
		if (grant_order.size() == 2) begin
			check_count("first store grant", grant_order[0], first);
			check_count("second store grant", grant_order[1], 3 - first);
		end
	endtask

	////////////////////
	// Tests

	initial begin
		int p0;
		int s0;
		reset = 1'b1;
		stall = 1'b0;
		for (int d = 0; d < 2; d++) begin
			for (int p = 1; p <= 2; p++) begin
				req[d][p] = 1'b0;
				valid[d][p] = 1'b0;
				len_f[d][p] = '0;
				stride_f[d][p] = '0;
				base_f[d][p] = '0;
			end
		end
		st_data[1] = '0;
		st_data[2] = '0;
		repeat (16) @(posedge clock);
		#2;
		reset = 1'b0;

		repeat (10) begin
			@(negedge clock);
			assert ({st_grant_1, st_grant_2, ld_grant_1, ld_grant_2} == 4'b0)
				else report_error("grant high without a request");
			assert ({st_ready_1, st_ready_2, ld_ready_1, ld_ready_2} == 4'b0)
				else report_error("ready high without a request");
			assert (ld_data_1 == '0 && ld_data_2 == '0) else report_error("load data not zero");
		end
		idle_cycles(1);
		finish_test("idle after reset");

		p0 = pulses[1];
		run_stream(0, 1, 'h10, 1, 8, 1'b0);
		check_count("store steps port 1", steps[0][1], 8);
		run_stream(1, 1, 'h10, 1, 8, 1'b0);
		idle_cycles(2);
		check_count("ld_ready_1 pulses", pulses[1] - p0, 8);
		finish_test("stride 1 store and load");

		p0 = pulses[2];
		run_stream(0, 2, 'hF0, 3, 12, 1'b0);	// Runs past the top and wraps
		run_stream(1, 2, 'hF0, 3, 12, 1'b0);
		run_stream(1, 2, 'hF3, 0, 5, 1'b0);
		idle_cycles(2);
		check_count("ld_ready_2 pulses", pulses[2] - p0, 17);
		finish_test("wrapping stride and stride 0");

		run_stream(0, 1, 'hA0, 1, 2, 1'b0);	// Port 1 granted last so port 2 wins
		tie_break(2, 'h80, 'h90);
		run_stream(0, 2, 'hA4, 1, 2, 1'b0);	// Port 1 lost the tie and now goes first
		tie_break(1, 'hB0, 'hC0);
		p0 = pulses[1];
		run_stream(1, 1, 'h80, 1, 6, 1'b0);
		run_stream(1, 1, 'h90, 2, 6, 1'b0);
		run_stream(1, 1, 'hB0, 1, 6, 1'b0);
		run_stream(1, 1, 'hC0, 2, 6, 1'b0);
		idle_cycles(2);
		check_count("ld_ready_1 pulses", pulses[1] - p0, 24);
		finish_test("store arbitration ties");

		p0 = pulses[1];
		s0 = steps[0][2];
		stall_mode = 1'b1;
		fork
			run_stream(0, 2, 'h40, 2, 20, 1'b1);
			run_stream(1, 1, 'h10, 1, 8, 1'b1);
		join
		idle_cycles(2);
		stall_mode = 1'b0;
		check_count("store steps port 2", steps[0][2] - s0, 20);
		check_count("ld_ready_1 pulses", pulses[1] - p0, 8);
		p0 = pulses[2];
		run_stream(1, 2, 'h40, 2, 20, 1'b0);
		idle_cycles(2);
		check_count("ld_ready_2 pulses", pulses[2] - p0, 20);
		finish_test("stall and valid gaps");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
mkdir -p build &&
verilator --binary --timing --assert -f sim.f --top-module dmem_tb \
	-Mdir build -o dmem_sim &&
./build/dmem_sim | tee build/sim.log &&
grep -q "all tests passed" build/sim.log &&
echo "simulation ok" ||
{
	echo "simulation FAILED"
	exit 1
}

/* sim.f */
source/dmem_pkg.sv
source/stream_arbiter.sv
source/agu.sv
source/dmem_array.sv
source/dmem_body.sv
bench/dmem_tb.sv

/* source/agu.sv */
`default_nettype none

module agu
	import dmem_pkg::*;
#(
	parameter int ADDR_BITS = 8
) (
	input  wire          clock,
	input  wire          reset,
	input  wire          start,			// First grant cycle, config is fresh
	input  wire          step,			// One word moves this cycle
	input  wire length_t length,
	input  wire stride_t stride,
	input  wire addr_t   base,
	output addr_t        address,		// Word address of this cycle
	output logic         end_access		// Step on the last word
);

	logic [ADDR_BITS-1:0] addr_q;		// Address of the next word
	length_t              remain_q;		// Words still to move
	logic [ADDR_BITS-1:0] cur_addr;
	length_t              cur_remain;
	logic [ADDR_BITS-1:0] next_addr;

	////////////////////
	// Current position

	// In the start cycle the registers are stale, so take the config directly
	always_comb begin
		if (start) begin
			cur_addr   = base[ADDR_BITS-1:0];
			cur_remain = length;
		end else begin
			cur_addr   = addr_q;
			cur_remain = remain_q;
		end
	end

	// Wraps naturally at the memory depth
	assign next_addr = cur_addr + ADDR_BITS'(stride);

	assign address    = addr_t'(cur_addr);
	assign end_access = step & (cur_remain == length_t'(1));

	////////////////////
	// Stream counter

	always_ff @(posedge clock) begin
		if (reset) begin
			addr_q   <= '0;
			remain_q <= '0;
		end else if (step) begin
			addr_q   <= next_addr;
			remain_q <= cur_remain - length_t'(1);
		end else if (start) begin
			addr_q   <= cur_addr;		// Hold config when the first step waits
			remain_q <= cur_remain;
		end
	end

endmodule

`default_nettype wire

/* source/dmem_array.sv */
`default_nettype none

module dmem_array
	import dmem_pkg::*;
#(
	parameter int ADDR_BITS = 8
) (
	input  wire        clock,
	input  wire        reset,
	input  wire logic  write,
	input  wire addr_t write_address,
	input  wire data_t write_data,
	input  wire logic  read,
	input  wire addr_t read_address,
	output data_t      read_data,		// Registered, one cycle after read
	output logic       read_valid
);

	data_t mem [2**ADDR_BITS];

	always_ff @(posedge clock) begin
		if (write) begin
			mem[write_address[ADDR_BITS-1:0]] <= write_data;
		end
	end

	always_ff @(posedge clock) begin
		if (read) begin
			read_data <= mem[read_address[ADDR_BITS-1:0]];
		end
	end

	// Marks each word out of the read register
	always_ff @(posedge clock) begin
		if (reset) begin
			read_valid <= 1'b0;
		end else begin
			read_valid <= read;
		end
	end

endmodule

`default_nettype wire

/* source/dmem_body.sv */
`default_nettype none

module dmem_body
	import dmem_pkg::*;
#(
	parameter int ADDR_BITS = 8
) (
	input  wire          clock,
	input  wire          reset,
	input  wire          stall,			// Global stall, holds both engines
	input  wire          st_req_1,
	input  wire          st_req_2,
	input  wire          ld_req_1,
	input  wire          ld_req_2,
	input  wire length_t st_length_1,
	input  wire length_t st_length_2,
	input  wire length_t ld_length_1,
	input  wire length_t ld_length_2,
	input  wire stride_t st_stride_1,
	input  wire stride_t st_stride_2,
	input  wire stride_t ld_stride_1,
	input  wire stride_t ld_stride_2,
	input  wire addr_t   st_base_1,
	input  wire addr_t   st_base_2,
	input  wire addr_t   ld_base_1,
	input  wire addr_t   ld_base_2,
	input  wire          st_valid_1,		// Store word present
	input  wire          st_valid_2,
	input  wire          ld_valid_1,		// Load requester can take a word
	input  wire          ld_valid_2,
	input  wire data_t   st_data_1,
	input  wire data_t   st_data_2,
	output logic         st_grant_1,
	output logic         st_grant_2,
	output logic         ld_grant_1,
	output logic         ld_grant_2,
	output logic         st_ready_1,
	output logic         st_ready_2,
	output data_t        ld_data_1,
	output data_t        ld_data_2,
	output logic         ld_ready_1,
	output logic         ld_ready_2
);

	logic    st_start, ld_start;
	logic    st_end, ld_end;
	logic    st_step, ld_step;
	length_t st_length, ld_length;
	stride_t st_stride, ld_stride;
	addr_t   st_base, ld_base;
	addr_t   st_address, ld_address;
	data_t   st_word;
	data_t   read_data;
	logic    read_valid;
	logic    ld_owner_2;			// Read in flight belongs to requester 2

	////////////////////
	// Transfer conditions

	assign st_step = ((st_grant_1 & st_valid_1) | (st_grant_2 & st_valid_2)) & ~stall;
	assign ld_step = ((ld_grant_1 & ld_valid_1) | (ld_grant_2 & ld_valid_2)) & ~stall;

	assign st_ready_1 = st_grant_1 & ~stall;
	assign st_ready_2 = st_grant_2 & ~stall;

	assign st_word = st_grant_2 ? st_data_2 : st_data_1;	// Granted store data

	////////////////////
	// Load return steering

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_owner_2 <= 1'b0;
		end else if (ld_step) begin
			ld_owner_2 <= ld_grant_2;
		end
	end

	assign ld_ready_1 = read_valid & ~ld_owner_2;
	assign ld_ready_2 = read_valid & ld_owner_2;
	assign ld_data_1  = ld_ready_1 ? read_data : '0;	// Zero between pulses
	assign ld_data_2  = ld_ready_2 ? read_data : '0;

	////////////////////
	// Store engine

	stream_arbiter arb_st (
		.clock      (clock),
		.reset      (reset),
		.req_1      (st_req_1),
		.req_2      (st_req_2),
		.length_1   (st_length_1),
		.length_2   (st_length_2),
		.stride_1   (st_stride_1),
		.stride_2   (st_stride_2),
		.base_1     (st_base_1),
		.base_2     (st_base_2),
		.end_access (st_end),
		.grant_1    (st_grant_1),
		.grant_2    (st_grant_2),
		.start      (st_start),
		.length     (st_length),
		.stride     (st_stride),
		.base       (st_base)
	);

	agu #(.ADDR_BITS(ADDR_BITS)) agu_st (
		.clock      (clock),
		.reset      (reset),
		.start      (st_start),
		.step       (st_step),
		.length     (st_length),
		.stride     (st_stride),
		.base       (st_base),
		.address    (st_address),
		.end_access (st_end)
	);

	// Load engine
	stream_arbiter arb_ld (
		.clock      (clock),
		.reset      (reset),
		.req_1      (ld_req_1),
		.req_2      (ld_req_2),
		.length_1   (ld_length_1),
		.length_2   (ld_length_2),
		.stride_1   (ld_stride_1),
		.stride_2   (ld_stride_2),
		.base_1     (ld_base_1),
		.base_2     (ld_base_2),
		.end_access (ld_end),
		.grant_1    (ld_grant_1),
		.grant_2    (ld_grant_2),
		.start      (ld_start),
		.length     (ld_length),
		.stride     (ld_stride),
		.base       (ld_base)
	);

	agu #(.ADDR_BITS(ADDR_BITS)) agu_ld (
		.clock      (clock),
		.reset      (reset),
		.start      (ld_start),
		.step       (ld_step),
		.length     (ld_length),
		.stride     (ld_stride),
		.base       (ld_base),
		.address    (ld_address),
		.end_access (ld_end)
	);

	dmem_array #(.ADDR_BITS(ADDR_BITS)) array (
		.clock         (clock),
		.reset         (reset),
		.write         (st_step),
		.write_address (st_address),
		.write_data    (st_word),
		.read          (ld_step),
		.read_address  (ld_address),
		.read_data     (read_data),
		.read_valid    (read_valid)
	);

endmodule

`default_nettype wire

/* source/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

	////////////////////
	// Word and stream fields

	// One memory word
	typedef logic [31:0] data_t;

	// Word address, taken modulo the memory depth
	typedef logic [9:0] addr_t;

	// Words per stream, 1 to 255
	typedef logic [7:0] length_t;

	// Unsigned step between words, 0 repeats the base
	typedef logic [3:0] stride_t;

	////////////////////
	// Arbiter FSM

	typedef enum logic [1:0] {
		arb_idle   = 2'd0,	// No stream granted
		arb_grant1 = 2'd1,	// Requester 1 owns the engine
		arb_grant2 = 2'd2	// Requester 2 owns the engine
	} arb_state_t;

endpackage

`default_nettype wire

/* source/stream_arbiter.sv */
`default_nettype none

module stream_arbiter
	import dmem_pkg::*;
(
	input  wire          clock,
	input  wire          reset,
	input  wire          req_1,			// Stream request, requester 1
	input  wire          req_2,			// Stream request, requester 2
	input  wire length_t length_1,
	input  wire length_t length_2,
	input  wire stride_t stride_1,
	input  wire stride_t stride_2,
	input  wire addr_t   base_1,
	input  wire addr_t   base_2,
	input  wire          end_access,		// Last word of the stream moved
	output logic         grant_1,
	output logic         grant_2,
	output logic         start,			// First grant cycle
	output length_t      length,			// Latched config of the winner
	output stride_t      stride,
	output addr_t        base
);

	arb_state_t state;
	logic       last_2;				// Requester 2 won most recently
	logic       win_1;
	logic       win_2;

	////////////////////
	// Alternating priority

	// On a tie the requester that did not win last time goes first
	always_comb begin
		win_1 = (state == arb_idle) & req_1 & (~req_2 | last_2);
		win_2 = (state == arb_idle) & req_2 & (~req_1 | ~last_2);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= arb_idle;
			last_2 <= 1'b0;		// Requester 1 counts as the last winner
			start  <= 1'b0;
		end else begin
			start <= win_1 | win_2;
			case (state)
				arb_idle: begin
					if (win_1) begin
						state  <= arb_grant1;
						last_2 <= 1'b0;
					end else if (win_2) begin
						state  <= arb_grant2;
						last_2 <= 1'b1;
					end
				end
				arb_grant1, arb_grant2: begin
					if (end_access) begin
						state <= arb_idle;	// Grant drops next cycle
					end
				end
				default: begin
					state <= arb_idle;
				end
			endcase
		end
	end

	////////////////////
	// Configuration latch

	// Captured at the grant edge, so the requester fields are free afterwards
	always_ff @(posedge clock) begin
		if (win_1) begin
			length <= length_1;
			stride <= stride_1;
			base   <= base_1;
		end else if (win_2) begin
			length <= length_2;
			stride <= stride_2;
			base   <= base_2;
		end
	end

	assign grant_1 = (state == arb_grant1);
	assign grant_2 = (state == arb_grant2);

endmodule

`default_nettype wire
